/* source/game_pkg.sv */
`default_nettype none

package game_pkg;

    ////////////////////////////////////////
    // Play-field geometry
    ////////////////////////////////////////

    localparam int COORD_W = 12;                     // Width of every x or y coordinate

    // Player and obstacle sprites are both square boxes of this side
    localparam logic [COORD_W-1:0] SPRITE_SIZE = 12'd16;

    ////////////////////////////////////////
    // Motion and damage timing
    ////////////////////////////////////////

    // Leftward movement of the obstacle per frame tick
    localparam logic [COORD_W-1:0] SCROLL_STEP = 12'd4;

    // Half a second of immunity after a hit at 60 frames per second
    localparam logic [4:0] INVULN_FRAMES = 5'd30;

    ////////////////////////////////////////
    // Hit points
    ////////////////////////////////////////

    localparam int HP_W = 2;                         // Width of the hit-point count

    localparam logic [HP_W-1:0] MAX_HP = 2'd3;       // Loaded on reset

endpackage

`default_nettype wire

/* source/obstacle_scroller.sv */
`timescale 1ns/1ps
`default_nettype none

// Holds the single obstacle in flight. A spawn request is taken only while
// the field is empty, then the obstacle walks left one step per frame tick
// until the next step would push it past x = 0.

module obstacle_scroller import game_pkg::*; (
    input  wire logic               pclk,
    input  wire logic               rst,
    input  wire logic               frame_tick,     // One pulse per video frame
    input  wire logic               spawn_valid,
    input  wire logic [COORD_W-1:0] spawn_x,
    input  wire logic [COORD_W-1:0] spawn_y,
    output      logic               spawn_ready,
    output      logic [COORD_W-1:0] obstacle_x,
    output      logic [COORD_W-1:0] obstacle_y,
    output      logic               obstacle_active
);

    logic spawn_take;       // Handshake completes this cycle
    logic at_left_edge;     // Next step would underflow
    logic step_now;         // Move the obstacle this cycle
    logic retire_now;       // Drop the obstacle this cycle

    ////////////////////////////////////////
    // Handshake and motion decisions
    ////////////////////////////////////////

    // Ready only with an empty field and outside reset
    assign spawn_ready = !obstacle_active && !rst;

    assign spawn_take = spawn_valid && spawn_ready;

    assign at_left_edge = (obstacle_x < SCROLL_STEP);

    // A tick only matters while something is on the field, so a tick on
    // the transfer cycle leaves the new obstacle where it was placed
    assign step_now   = obstacle_active && frame_tick && !at_left_edge;
    assign retire_now = obstacle_active && frame_tick && at_left_edge;

    ////////////////////////////////////////
    // Active flag
    ////////////////////////////////////////

    always_ff @(posedge pclk) begin
        if (rst) begin
            obstacle_active <= 1'b0;
        end else if (spawn_take) begin
            obstacle_active <= 1'b1;                // Visible from the next cycle
        end else if (retire_now) begin
            obstacle_active <= 1'b0;                // Obstacle has left the field
        end
    end

    ////////////////////////////////////////
    // Position registers
    ////////////////////////////////////////

    always_ff @(posedge pclk) begin
        if (spawn_take) begin
            obstacle_x <= spawn_x;                  // Load spawn position as given
            obstacle_y <= spawn_y;
        end else if (step_now) begin
            obstacle_x <= obstacle_x - SCROLL_STEP;
        end
    end

    // Only x scrolls during the flight

endmodule

`default_nettype wire

/* source/collision_detector.sv */
`timescale 1ns/1ps
`default_nettype none

// Overlap check between the player box at the mouse position and the
// obstacle box. A hit gives a one-cycle damage pulse, after which overlaps
// are ignored until INVULN_FRAMES frame ticks have passed.

module collision_detector import game_pkg::*; (
    input  wire logic               pclk,
    input  wire logic               rst,
    input  wire logic               frame_tick,
    input  wire logic               game_over,      // From the hit-point tracker
    input  wire logic [COORD_W-1:0] mouse_x,
    input  wire logic [COORD_W-1:0] mouse_y,
    input  wire logic [COORD_W-1:0] obstacle_x,
    input  wire logic [COORD_W-1:0] obstacle_y,
    input  wire logic               obstacle_active,
    output      logic               damage
);

    localparam logic ST_CHECK  = 1'b0;              // Looking for a hit
    localparam logic ST_INVULN = 1'b1;              // Counting frames with hits ignored

    logic                              state, state_nxt;
    logic                              damage_nxt;
    logic [$bits(INVULN_FRAMES)-1:0]   frame_cnt, frame_cnt_nxt;

    logic [COORD_W-1:0] dist_x;
    logic [COORD_W-1:0] dist_y;
    logic               overlap;

    ////////////////////////////////////////
    // Box-overlap test
    ////////////////////////////////////////

    // Absolute differences by subtracting the smaller from the larger
    assign dist_x = (mouse_x >= obstacle_x) ? (mouse_x - obstacle_x)
                                            : (obstacle_x - mouse_x);
    assign dist_y = (mouse_y >= obstacle_y) ? (mouse_y - obstacle_y)
                                            : (obstacle_y - mouse_y);

    // Equal-sized boxes touch when both distances are under one side
    assign overlap = (dist_x < SPRITE_SIZE) && (dist_y < SPRITE_SIZE);

    ////////////////////////////////////////
    // State registers
    ////////////////////////////////////////

    always_ff @(posedge pclk) begin
        if (rst) begin
            state     <= ST_CHECK;
            damage    <= 1'b0;
            frame_cnt <= '0;
        end else begin
            state     <= state_nxt;
            damage    <= damage_nxt;
            frame_cnt <= frame_cnt_nxt;
        end
    end

    ////////////////////////////////////////
    // Next-state logic
    ////////////////////////////////////////

    always_comb begin
        state_nxt     = state;
        damage_nxt    = 1'b0;                       // Pulse lasts a single cycle
        frame_cnt_nxt = frame_cnt;
        case (state)
            ST_CHECK: begin
                if (obstacle_active && !game_over && overlap) begin
                    damage_nxt    = 1'b1;
                    frame_cnt_nxt = '0;
                    state_nxt     = ST_INVULN;
                end
            end
            ST_INVULN: begin
                if (frame_tick) begin
                    if (frame_cnt == INVULN_FRAMES - 1'b1) begin
                        frame_cnt_nxt = '0;         // Last tick of the window
                        state_nxt     = ST_CHECK;
                    end else begin
                        frame_cnt_nxt = frame_cnt + 1'b1;
                    end
                end
            end
            default: state_nxt = ST_CHECK;
        endcase
    end

endmodule

`default_nettype wire

/* source/hp_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

// Counts the player's remaining hit points. Each damage pulse takes one
// away; at zero the game is over and further pulses change nothing.

module hp_tracker import game_pkg::*; (
    input  wire logic            pclk,
    input  wire logic            rst,
    input  wire logic            damage,        // One-cycle pulse per hit
    output      logic [HP_W-1:0] hp,
    output      logic            game_over
);

    logic hp_empty;

    ////////////////////////////////////////
    // Hit-point counter
    ////////////////////////////////////////

    assign hp_empty = (hp == '0);

    always_ff @(posedge pclk) begin
        if (rst) begin
            hp <= MAX_HP;                       // Full health after reset
        end else if (damage && !hp_empty) begin
            hp <= hp - 1'b1;                    // Saturates at zero
        end
    end

    ////////////////////////////////////////
    // Game-over flag
    ////////////////////////////////////////

    // Follows hp directly, so it rises together with the last decrement
    assign game_over = hp_empty;

endmodule

`default_nettype wire

/* source/game_core.sv */
`timescale 1ns/1ps
`default_nettype none

// Play-field top level. The scroller feeds the obstacle to the detector,
// the detector's damage pulse drives the hit-point tracker, and game over
// from the tracker turns the detector off.

module game_core import game_pkg::*; (
    input  wire logic               pclk,
    input  wire logic               rst,
    input  wire logic               frame_tick,
    input  wire logic [COORD_W-1:0] mouse_x,
    input  wire logic [COORD_W-1:0] mouse_y,
    input  wire logic               spawn_valid,
    input  wire logic [COORD_W-1:0] spawn_x,
    input  wire logic [COORD_W-1:0] spawn_y,
    output      logic               spawn_ready,
    output      logic [COORD_W-1:0] obstacle_x,
    output      logic [COORD_W-1:0] obstacle_y,
    output      logic               obstacle_active,
    output      logic               damage,
    output      logic [HP_W-1:0]    hp,
    output      logic               game_over
);

    ////////////////////////////////////////
    // Obstacle in flight
    ////////////////////////////////////////

    obstacle_scroller u_scroller (
        .pclk            (pclk),
        .rst             (rst),
        .frame_tick      (frame_tick),
        .spawn_valid     (spawn_valid),
        .spawn_x         (spawn_x),
        .spawn_y         (spawn_y),
        .spawn_ready     (spawn_ready),
        .obstacle_x      (obstacle_x),
        .obstacle_y      (obstacle_y),
        .obstacle_active (obstacle_active)
    );

    ////////////////////////////////////////
    // Hit detection
    ////////////////////////////////////////

    collision_detector u_detector (
        .pclk            (pclk),
        .rst             (rst),
        .frame_tick      (frame_tick),
        .game_over       (game_over),       // Loop back from the tracker
        .mouse_x         (mouse_x),
        .mouse_y         (mouse_y),
        .obstacle_x      (obstacle_x),
        .obstacle_y      (obstacle_y),
        .obstacle_active (obstacle_active),
        .damage          (damage)
    );

    ////////////////////////////////////////
    // Health
    ////////////////////////////////////////

    hp_tracker u_hp (
        .pclk      (pclk),
        .rst       (rst),
        .damage    (damage),
        .hp        (hp),
        .game_over (game_over)
    );

endmodule

`default_nettype wire

/* test/game_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module game_core_sva import game_pkg::*; (
    input wire logic            pclk,
    input wire logic            rst,
    input wire logic            damage,
    input wire logic            spawn_ready,
    input wire logic            obstacle_active,
    input wire logic [HP_W-1:0] hp
);

    // Pulse is exactly one cycle wide
    a_damage_one_cycle: assert property (
        @(posedge pclk) disable iff (rst) damage |=> !damage
    ) else $error("damage was high on two consecutive cycles");

    // No new spawn while an obstacle is in flight
    a_no_ready_in_flight: assert property (
        @(posedge pclk) disable iff (rst) obstacle_active |-> !spawn_ready
    ) else $error("spawn_ready high while an obstacle is active");

    a_hp_never_rises: assert property (
        @(posedge pclk) disable iff (rst) hp <= $past(hp)
    ) else $error("hp rose outside of reset");

endmodule

bind game_core game_core_sva u_sva (
    .pclk            (pclk),
    .rst             (rst),
    .damage          (damage),
    .spawn_ready     (spawn_ready),
    .obstacle_active (obstacle_active),
    .hp              (hp)
);

`default_nettype wire

/* test/tb_game_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_game_core import game_pkg::*; ();

    localparam int    RNG_SEED  = 26293;
    localparam string VEC_FILE  = "test/game_vectors.txt";

    logic               pclk, rst, frame_tick, spawn_valid;
    logic [COORD_W-1:0] mouse_x, mouse_y, spawn_x, spawn_y;
    logic               spawn_ready, obstacle_active, damage, game_over;
    logic [COORD_W-1:0] obstacle_x, obstacle_y;
    logic [HP_W-1:0]    hp;

    // Reference model state
    logic               m_active, m_inv, m_damage;
    logic [COORD_W-1:0] m_x, m_y;
    logic [HP_W-1:0]    m_hp;
    int                 m_ticks;

    logic [COORD_W-1:0] v_sx[$], v_sy[$], v_mx[$], v_my[$];
    int                 v_frames[$];
    int                 total_frames = 0;
    bit                 vectors_loaded = 1'b0;
    bit                 vectors_opened = 1'b0;
    int                 pass_cnt = 0, fail_cnt = 0, test_err = 0;
    int                 pulses_seen, pulses_model;

    game_core DUT (.*);

    initial pclk = 1'b0;
    always #2 pclk = ~pclk;                         // 4 ns period

    ////////////////////////////////////////
    // Model and checks
    ////////////////////////////////////////

    function automatic logic boxes_overlap(input logic [COORD_W-1:0] ax, ay, bx, by);
        int dx;
        int dy;
        dx = int'(ax) - int'(bx);
        dy = int'(ay) - int'(by);
        if (dx < 0) dx = -dx;
        if (dy < 0) dy = -dy;
        return (dx < int'(SPRITE_SIZE)) && (dy < int'(SPRITE_SIZE));
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected, actual);
        if (actual !== expected) begin
            test_err++;
            $display("ERROR %s expected 0x%0h got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // Advance the model by one clock with the inputs driven for this cycle
    task automatic predict_cycle();
        logic take;
        logic hit;
        take = spawn_valid && !m_active;
        hit  = !m_inv && m_active && (m_hp != '0) && boxes_overlap(mouse_x, mouse_y, m_x, m_y);
        if (m_damage && m_hp != '0) m_hp = m_hp - 1'b1;     // Last cycle's pulse lands
        m_damage = hit;
        if (hit) begin
            pulses_model++;
            m_inv   = 1'b1;
            m_ticks = 0;
        end else if (m_inv && frame_tick) begin
            m_ticks++;
            if (m_ticks == int'(INVULN_FRAMES)) begin
                m_inv   = 1'b0;
                m_ticks = 0;
            end
        end
        if (take) begin
            m_active = 1'b1;
            m_x      = spawn_x;
            m_y      = spawn_y;
        end else if (m_active && frame_tick) begin
            if (m_x < SCROLL_STEP) m_active = 1'b0;
            else m_x = m_x - SCROLL_STEP;
        end
    endtask

    task automatic compare_outputs();
        compare_value("spawn_ready", 32'(!m_active), 32'(spawn_ready));
        compare_value("obstacle_active", 32'(m_active), 32'(obstacle_active));
        compare_value("damage", 32'(m_damage), 32'(damage));
        compare_value("hp", 32'(m_hp), 32'(hp));
        compare_value("game_over", 32'(m_hp == '0), 32'(game_over));
        if (m_active) begin
            compare_value("obstacle_x", 32'(m_x), 32'(obstacle_x));
            compare_value("obstacle_y", 32'(m_y), 32'(obstacle_y));
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Entered and left 0.5 ns after a rising edge
    task automatic drive_cycle(input logic tick);
        frame_tick = tick;
        predict_cycle();
        @(posedge pclk);
        #0.5;
        compare_outputs();
        if (damage) pulses_seen++;
    endtask

    task automatic play_frame();
        int gap;
        gap = $urandom_range(3, 0);                 // Idle cycles before the tick
        repeat (gap) drive_cycle(1'b0);
        drive_cycle(1'b1);
    endtask

    task automatic log_result(input string what);
        if (test_err == 0) pass_cnt++;
        else fail_cnt++;
        $display("%s : %s", what, (test_err == 0) ? "ok" : "mismatch");
    endtask

    task automatic play_scenario(input int idx);
        int    delay;
        int    gap;
        int    waited;
        bit    held;
        bit    taken;
        string desc;
        test_err     = 0;
        pulses_seen  = 0;
        pulses_model = 0;
        waited       = 0;
        taken        = 1'b0;
        mouse_x = v_mx[idx];
        mouse_y = v_my[idx];
        delay = $urandom_range(5, 0);
        repeat (delay) drive_cycle(1'b0);
        spawn_x     = v_sx[idx];
        spawn_y     = v_sy[idx];
        spawn_valid = 1'b1;
        held        = !spawn_ready;                 // Obstacle still in flight
        gap         = $urandom_range(3, 0);
        // Frames keep running so a held request can see the field clear
        while (!taken) begin
            taken = spawn_ready;
            if (gap == 0) begin
                drive_cycle(1'b1);
                gap = $urandom_range(3, 0);
                waited++;
            end else begin
                drive_cycle(1'b0);
                gap--;
            end
        end
        spawn_valid = 1'b0;
        repeat (v_frames[idx]) play_frame();
        repeat (2) drive_cycle(1'b0);               // Let a late pulse reach hp
        compare_value("damage_count", 32'(pulses_model), 32'(pulses_seen));
        desc = $sformatf("Scenario %0d spawn (%0d,%0d) mouse (%0d,%0d)",
                         idx, v_sx[idx], v_sy[idx], v_mx[idx], v_my[idx]);
        desc = {desc, $sformatf(" held %0d waited %0d pulses %0d hp %0d",
                                held, waited, pulses_seen, hp)};
        log_result(desc);
    endtask

    task automatic read_vectors(output bit opened);
        int    fd;
        int    n;
        int    sx, sy, mx, my, fr;
        string line;
        fd     = $fopen(VEC_FILE, "r");
        opened = (fd != 0);
        if (opened) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#") continue;     // Blank or column notes
                n = $sscanf(line, "%d %d %d %d %d", sx, sy, mx, my, fr);
                if (n == 5) begin
                    v_sx.push_back(COORD_W'(sx));
                    v_sy.push_back(COORD_W'(sy));
                    v_mx.push_back(COORD_W'(mx));
                    v_my.push_back(COORD_W'(my));
                    v_frames.push_back(fr);
                    total_frames += fr;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        frame_tick  = 1'b0;
        spawn_valid = 1'b0;
        spawn_x     = '0;
        spawn_y     = '0;
        mouse_x     = '0;
        mouse_y     = '0;
        m_active    = 1'b0;
        m_inv       = 1'b0;
        m_damage    = 1'b0;
        m_x         = '0;
        m_y         = '0;
        m_hp        = MAX_HP;
        m_ticks     = 0;
        void'($urandom(RNG_SEED));
        read_vectors(vectors_opened);
        if (!vectors_opened) begin
            $display("Could not open the vector file %s", VEC_FILE);
            $display("SIMULATION FAILED");
        end else begin
            vectors_loaded = 1'b1;
            repeat (5) @(posedge pclk);
            #0.5;
            compare_value("spawn_ready", 32'(1'b0), 32'(spawn_ready));
            compare_value("obstacle_active", 32'(1'b0), 32'(obstacle_active));
            compare_value("damage", 32'(1'b0), 32'(damage));
            compare_value("hp", 32'(MAX_HP), 32'(hp));
            compare_value("game_over", 32'(1'b0), 32'(game_over));
            rst = 1'b0;
            drive_cycle(1'b0);                      // Ready rises once rst is low
            log_result("Reset state");
            for (int i = 0; i < v_frames.size(); i++) play_scenario(i);
            $display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
        end
        $finish;
    end

    initial begin
        wait (vectors_loaded);
        repeat (total_frames * 8 + 1000) @(posedge pclk);
        $display("Timeout, the scenarios did not finish within %0d cycles",
                 total_frames * 8 + 1000);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
source/game_pkg.sv
source/obstacle_scroller.sv
source/collision_detector.sv
source/hp_tracker.sv
source/game_core.sv
test/game_core_sva.sv
test/tb_game_core.sv

/* Makefile */
SIM      = verilator
VFLAGS   = --binary --timing --assert
TOP      = tb_game_core
FILELIST = project.f
OBJ_DIR  = obj_dir
PASS_MSG = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/game_vectors.txt */
# spawn_x spawn_y mouse_x mouse_y frames, all decimal, one scenario per line
# Scenarios run back to back without reset, hp carries over
100 200 500  50  30
120 100  40 100  50
200 300 190 305  10
 60  40 600 600  60
400  80 300  85 110
100  80  60  80  40
